// ==== ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// integer datapath width
`define EX_XLEN    32

// register file address width
`define EX_REG_AW  5

// one multiply/divide step per operand bit
`define EX_MD_ITER 32

`endif

// ==== ex_pkg.sv ====
package ex_pkg;

    // decoded operation, one label per supported instruction
    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_NOR,
        OP_LUI,
        OP_SLL,
        OP_SLLV,
        OP_SRL,
        OP_SRLV,
        OP_SRA,
        OP_SRAV,
        OP_ADD,
        OP_ADDI,
        OP_ADDU,
        OP_ADDIU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_SLTI,
        OP_SLTIU,
        OP_JAL,
        OP_JALR,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } op_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_dir_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    // multiply/divide sequencer
    typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_DONE} md_state_e;

endpackage

// ==== ex_alu.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_alu (
    input  ex_pkg::op_e                op,
    input  logic [`EX_XLEN-1:0]        rs_val,
    input  logic [`EX_XLEN-1:0]        rt_val,
    input  logic [`EX_XLEN-1:0]        return_addr,
    input  logic [`EX_XLEN-1:0]        hi,
    input  logic [`EX_XLEN-1:0]        lo,
    input  logic [15:0]                imm,
    input  logic [4:0]                 shamt,
    input  logic [`EX_REG_AW-1:0]      rt,
    input  logic [`EX_REG_AW-1:0]      rd,
    output logic [`EX_XLEN-1:0]        alu_result,
    output logic [`EX_REG_AW-1:0]      alu_dest,
    output logic                       alu_overflow,
    output logic [`EX_XLEN-1:0]        mem_addr,
    output ex_pkg::mem_dir_e           mem_dir,
    output ex_pkg::mem_size_e          mem_size,
    output logic                       mem_signed
);

    // JAL always links through r31
    localparam logic [`EX_REG_AW-1:0] LINK_REG = 31;

    logic [`EX_XLEN-1:0] imm_sext;
    logic [`EX_XLEN-1:0] imm_zext;
    logic [`EX_XLEN-1:0] add_b;
    logic [`EX_XLEN-1:0] add_sum;
    logic [`EX_XLEN-1:0] sub_diff;
    logic [`EX_XLEN-1:0] eff_addr;
    logic [4:0]          shift_amt;
    logic                add_ovf;
    logic                sub_ovf;
    logic                lt_signed;
    logic                lt_unsigned;

    assign imm_sext = {{(`EX_XLEN-16){imm[15]}}, imm};
    assign imm_zext = {{(`EX_XLEN-16){1'b0}}, imm};

    // immediate forms add the sign-extended immediate
    assign add_b    = (op == ex_pkg::OP_ADDI || op == ex_pkg::OP_ADDIU) ? imm_sext : rt_val;
    assign add_sum  = rs_val + add_b;
    assign sub_diff = rs_val - rt_val;
    assign eff_addr = rs_val + imm_sext;

    // overflow when operand signs agree but the result sign differs
    assign add_ovf = (rs_val[`EX_XLEN-1] == add_b[`EX_XLEN-1])
                     && (add_sum[`EX_XLEN-1] != rs_val[`EX_XLEN-1]);
    assign sub_ovf = (rs_val[`EX_XLEN-1] != rt_val[`EX_XLEN-1])
                     && (sub_diff[`EX_XLEN-1] != rs_val[`EX_XLEN-1]);

    // SLTI/SLTIU compare against the sign-extended immediate too
    always_comb
    begin
        if (op == ex_pkg::OP_SLTI || op == ex_pkg::OP_SLTIU)
        begin
            lt_signed   = $signed(rs_val) < $signed(imm_sext);
            lt_unsigned = rs_val < imm_sext;
        end
        else
        begin
            lt_signed   = $signed(rs_val) < $signed(rt_val);
            lt_unsigned = rs_val < rt_val;
        end
    end

    // variable forms take the low five bits of rs
    assign shift_amt = (op == ex_pkg::OP_SLLV || op == ex_pkg::OP_SRLV || op == ex_pkg::OP_SRAV)
                       ? rs_val[4:0] : shamt;

    always_comb
    begin
        alu_result   = '0;
        alu_dest     = '0;
        alu_overflow = 1'b0;
        case (op)
            ex_pkg::OP_AND:  begin alu_result = rs_val & rt_val;    alu_dest = rd; end
            ex_pkg::OP_ANDI: begin alu_result = rs_val & imm_zext;  alu_dest = rt; end
            ex_pkg::OP_OR:   begin alu_result = rs_val | rt_val;    alu_dest = rd; end
            ex_pkg::OP_ORI:  begin alu_result = rs_val | imm_zext;  alu_dest = rt; end
            ex_pkg::OP_XOR:  begin alu_result = rs_val ^ rt_val;    alu_dest = rd; end
            ex_pkg::OP_XORI: begin alu_result = rs_val ^ imm_zext;  alu_dest = rt; end
            ex_pkg::OP_NOR:  begin alu_result = ~(rs_val | rt_val); alu_dest = rd; end
            ex_pkg::OP_LUI:
            begin
                alu_result = {imm, {(`EX_XLEN-16){1'b0}}};
                alu_dest   = rt;
            end
            ex_pkg::OP_SLL, ex_pkg::OP_SLLV:
            begin
                alu_result = rt_val << shift_amt;
                alu_dest   = rd;
            end
            ex_pkg::OP_SRL, ex_pkg::OP_SRLV:
            begin
                alu_result = rt_val >> shift_amt;
                alu_dest   = rd;
            end
            ex_pkg::OP_SRA, ex_pkg::OP_SRAV:
            begin
                alu_result = $signed(rt_val) >>> shift_amt;
                alu_dest   = rd;
            end
            // trapping forms suppress the writeback on overflow
            ex_pkg::OP_ADD, ex_pkg::OP_ADDI:
            begin
                alu_result   = add_sum;
                alu_overflow = add_ovf;
                alu_dest     = add_ovf ? '0 : ((op == ex_pkg::OP_ADD) ? rd : rt);
            end
            ex_pkg::OP_ADDU:  begin alu_result = add_sum; alu_dest = rd; end
            ex_pkg::OP_ADDIU: begin alu_result = add_sum; alu_dest = rt; end
            ex_pkg::OP_SUB:
            begin
                alu_result   = sub_diff;
                alu_overflow = sub_ovf;
                alu_dest     = sub_ovf ? '0 : rd;
            end
            ex_pkg::OP_SUBU:  begin alu_result = sub_diff; alu_dest = rd; end
            ex_pkg::OP_SLT:   begin alu_result = `EX_XLEN'(lt_signed);   alu_dest = rd; end
            ex_pkg::OP_SLTU:  begin alu_result = `EX_XLEN'(lt_unsigned); alu_dest = rd; end
            ex_pkg::OP_SLTI:  begin alu_result = `EX_XLEN'(lt_signed);   alu_dest = rt; end
            ex_pkg::OP_SLTIU: begin alu_result = `EX_XLEN'(lt_unsigned); alu_dest = rt; end
            ex_pkg::OP_JAL:   begin alu_result = return_addr; alu_dest = LINK_REG; end
            ex_pkg::OP_JALR:  begin alu_result = return_addr; alu_dest = rd; end
            ex_pkg::OP_MFHI:  begin alu_result = hi; alu_dest = rd; end
            ex_pkg::OP_MFLO:  begin alu_result = lo; alu_dest = rd; end
            // loads carry the address along, data comes back from memory
            ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_LH, ex_pkg::OP_LHU, ex_pkg::OP_LW:
            begin
                alu_result = eff_addr;
                alu_dest   = rt;
            end
            // store data rides on the result bus
            ex_pkg::OP_SB, ex_pkg::OP_SH, ex_pkg::OP_SW:
                alu_result = rt_val;
            default:
                alu_result = '0;
        endcase
    end

    // memory access direction, size and extension
    always_comb
    begin
        mem_addr   = eff_addr;
        mem_signed = 1'b1;
        case (op)
            ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_LH, ex_pkg::OP_LHU, ex_pkg::OP_LW:
                mem_dir = ex_pkg::MEM_LOAD;
            ex_pkg::OP_SB, ex_pkg::OP_SH, ex_pkg::OP_SW:
                mem_dir = ex_pkg::MEM_STORE;
            default:
            begin
                mem_dir  = ex_pkg::MEM_NONE;
                mem_addr = '0;
            end
        endcase
        case (op)
            ex_pkg::OP_LB, ex_pkg::OP_LBU, ex_pkg::OP_SB:
                mem_size = ex_pkg::MEM_BYTE;
            ex_pkg::OP_LH, ex_pkg::OP_LHU, ex_pkg::OP_SH:
                mem_size = ex_pkg::MEM_HALF;
            default:
                mem_size = ex_pkg::MEM_WORD;
        endcase
        if (op == ex_pkg::OP_LBU || op == ex_pkg::OP_LHU)
            mem_signed = 1'b0;
    end

endmodule

// ==== ex_md_ctrl.sv ====
`timescale 1ns/100ps

module ex_md_ctrl (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  ex_pkg::op_e op,
    input  logic        last_iter,
    output logic        md_start,
    output logic        md_step,
    output logic        hilo_load,
    output logic        busy
);

    ex_pkg::md_state_e state;
    ex_pkg::md_state_e state_next;
    logic              is_md_op;

    always_comb
    begin
        case (op)
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_DIV, ex_pkg::OP_DIVU:
                is_md_op = 1'b1;
            default:
                is_md_op = 1'b0;
        endcase
    end

    // launch in the issue cycle, operands are latched on this edge
    assign md_start = in_valid && is_md_op;

    always_comb
    begin
        state_next = state;
        case (state)
            ex_pkg::MD_IDLE:
                if (md_start)
                    state_next = ex_pkg::MD_RUN;
            ex_pkg::MD_RUN:
                if (last_iter)
                    state_next = ex_pkg::MD_DONE;
            default:
                state_next = ex_pkg::MD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= ex_pkg::MD_IDLE;
        else
            state <= state_next;
    end

    // one step per cycle in RUN, hi/lo written in DONE
    assign md_step   = (state == ex_pkg::MD_RUN);
    assign hilo_load = (state == ex_pkg::MD_DONE);
    assign busy      = (state != ex_pkg::MD_IDLE);

endmodule

// ==== ex_iter_counter.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_iter_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic md_start,
    input  logic md_step,
    output logic last_iter
);

    localparam int CNT_W = $clog2(`EX_MD_ITER);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (md_start)
            count <= '0;
        else if (md_step)
            count <= count + 1'b1;
    end

    // count holds the steps already taken
    assign last_iter = md_step && (count == CNT_W'(`EX_MD_ITER - 1));

endmodule

// ==== ex_md_datapath.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_md_datapath (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  ex_pkg::op_e         op,
    input  logic [`EX_XLEN-1:0] rs_val,
    input  logic [`EX_XLEN-1:0] rt_val,
    input  logic                md_start,
    input  logic                md_step,
    input  logic                hilo_load,
    output logic [`EX_XLEN-1:0] hi,
    output logic [`EX_XLEN-1:0] lo
);

    // acc is the upper product half or the partial remainder
    logic [`EX_XLEN-1:0]    acc;
    // one bit per iteration, multiplier in and quotient out
    logic [`EX_MD_ITER-1:0] quo;
    logic [`EX_XLEN-1:0]    operand_b;
    logic                   is_div;
    logic                   neg_main;
    logic                   neg_rem;

    logic                   op_div;
    logic                   op_signed;
    logic [`EX_XLEN-1:0]    mag_a;
    logic [`EX_XLEN-1:0]    mag_b;
    logic [`EX_XLEN:0]      add_sum;
    logic [`EX_XLEN:0]      trial;
    logic [2*`EX_XLEN-1:0]  prod;
    logic [2*`EX_XLEN-1:0]  prod_fix;
    logic [`EX_XLEN-1:0]    quo_fix;
    logic [`EX_XLEN-1:0]    rem_fix;

    assign op_div    = (op == ex_pkg::OP_DIV) || (op == ex_pkg::OP_DIVU);
    assign op_signed = (op == ex_pkg::OP_MULT) || (op == ex_pkg::OP_DIV);

    // work on magnitudes, signs are applied at the end
    assign mag_a = (op_signed && rs_val[`EX_XLEN-1]) ? -rs_val : rs_val;
    assign mag_b = (op_signed && rt_val[`EX_XLEN-1]) ? -rt_val : rt_val;

    // shift-add step
    assign add_sum = {1'b0, acc} + (quo[0] ? {1'b0, operand_b} : '0);

    // restoring step, trial[XLEN] set means the subtract went negative
    assign trial = {acc, quo[`EX_MD_ITER-1]} - {1'b0, operand_b};

    always_ff @(posedge clk)
    begin
        if (md_start)
        begin
            acc       <= '0;
            quo       <= mag_a;
            operand_b <= mag_b;
            is_div    <= op_div;
            neg_main  <= op_signed && (rs_val[`EX_XLEN-1] ^ rt_val[`EX_XLEN-1]);
            neg_rem   <= op_signed && op_div && rs_val[`EX_XLEN-1];
        end
        else if (md_step)
        begin
            if (!is_div)
                {acc, quo} <= {add_sum, quo[`EX_MD_ITER-1:1]};
            else if (!trial[`EX_XLEN])
            begin
                acc <= trial[`EX_XLEN-1:0];
                quo <= {quo[`EX_MD_ITER-2:0], 1'b1};
            end
            else
            begin
                acc <= {acc[`EX_XLEN-2:0], quo[`EX_MD_ITER-1]};
                quo <= {quo[`EX_MD_ITER-2:0], 1'b0};
            end
        end
    end

    // sign fix-up, divide by zero falls out as all-ones quotient
    assign prod     = {acc, quo};
    assign prod_fix = neg_main ? -prod : prod;
    assign quo_fix  = neg_main ? -quo : quo;
    assign rem_fix  = neg_rem ? -acc : acc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (hilo_load)
        begin
            if (is_div)
            begin
                hi <= rem_fix;
                lo <= quo_fix;
            end
            else
            begin
                hi <= prod_fix[2*`EX_XLEN-1:`EX_XLEN];
                lo <= prod_fix[`EX_XLEN-1:0];
            end
        end
        else if (in_valid && op == ex_pkg::OP_MTHI)
            hi <= rs_val;
        else if (in_valid && op == ex_pkg::OP_MTLO)
            lo <= rs_val;
    end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  ex_pkg::op_e           op,
    input  logic [`EX_XLEN-1:0]   rs_val,
    input  logic [`EX_XLEN-1:0]   rt_val,
    input  logic [15:0]           imm,
    input  logic [4:0]            shamt,
    input  logic [`EX_REG_AW-1:0] rt,
    input  logic [`EX_REG_AW-1:0] rd,
    input  logic [`EX_XLEN-1:0]   return_addr,
    output logic                  out_valid,
    output logic [`EX_XLEN-1:0]   result,
    output logic [`EX_REG_AW-1:0] dest_reg,
    output logic [`EX_XLEN-1:0]   mem_addr,
    output ex_pkg::mem_dir_e      mem_dir,
    output ex_pkg::mem_size_e     mem_size,
    output logic                  mem_signed,
    output logic                  overflow,
    output logic                  busy
);

    logic [`EX_XLEN-1:0]   alu_result;
    logic [`EX_REG_AW-1:0] alu_dest;
    logic                  alu_overflow;
    logic [`EX_XLEN-1:0]   alu_mem_addr;
    ex_pkg::mem_dir_e      alu_mem_dir;
    ex_pkg::mem_size_e     alu_mem_size;
    logic                  alu_mem_signed;
    logic [`EX_XLEN-1:0]   hi;
    logic [`EX_XLEN-1:0]   lo;
    logic                  md_start;
    logic                  md_step;
    logic                  hilo_load;
    logic                  last_iter;

    ex_alu u_ex_alu (
        .op           (op),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .return_addr  (return_addr),
        .hi           (hi),
        .lo           (lo),
        .imm          (imm),
        .shamt        (shamt),
        .rt           (rt),
        .rd           (rd),
        .alu_result   (alu_result),
        .alu_dest     (alu_dest),
        .alu_overflow (alu_overflow),
        .mem_addr     (alu_mem_addr),
        .mem_dir      (alu_mem_dir),
        .mem_size     (alu_mem_size),
        .mem_signed   (alu_mem_signed)
    );

    ex_md_ctrl u_ex_md_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .last_iter (last_iter),
        .md_start  (md_start),
        .md_step   (md_step),
        .hilo_load (hilo_load),
        .busy      (busy)
    );

    ex_iter_counter u_ex_iter_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .md_start  (md_start),
        .md_step   (md_step),
        .last_iter (last_iter)
    );

    ex_md_datapath u_ex_md_datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .md_start  (md_start),
        .md_step   (md_step),
        .hilo_load (hilo_load),
        .hi        (hi),
        .lo        (lo)
    );

    // stage register, control half
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
            overflow  <= 1'b0;
            dest_reg  <= '0;
            mem_dir   <= ex_pkg::MEM_NONE;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
            begin
                overflow <= alu_overflow;
                dest_reg <= alu_dest;
                mem_dir  <= alu_mem_dir;
            end
        end
    end

    // payload half
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            result     <= alu_result;
            mem_addr   <= alu_mem_addr;
            mem_size   <= alu_mem_size;
            mem_signed <= alu_mem_signed;
        end
    end

endmodule

// ==== ex_stage_checker.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module ex_stage_checker (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic out_valid,
    input logic busy
);

    // multiply/divide occupancy, steps plus the hi/lo write
    localparam int BUSY_LEN = `EX_MD_ITER + 1;

    // issuer must hold off while the multiply/divide unit runs
    no_issue_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> !in_valid
    ) else $error("in_valid asserted while busy");

    busy_stays_high: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(busy) |-> ##(BUSY_LEN - 1) busy
    ) else $error("busy dropped early");

    busy_ends: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(busy) |-> ##BUSY_LEN !busy
    ) else $error("busy held too long");

    valid_follows_issue: assert property (
        @(posedge clk) disable iff (!arst_n) in_valid |=> out_valid
    ) else $error("out_valid missing after issue");

    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> (!out_valid && !busy)
    ) else $error("out_valid or busy high in reset");

endmodule

bind ex_stage ex_stage_checker u_ex_stage_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .busy      (busy)
);

// ==== tb_ex_stage.sv ====
`timescale 1ns/100ps

`include "ex_cfg.svh"

module tb_ex_stage;

    localparam logic [4:0] RT_A = 5'd5;
    localparam logic [4:0] RD_A = 5'd9;

    typedef struct {
        ex_pkg::op_e       op;
        logic [31:0]       rs;
        logic [31:0]       rt;
        logic [15:0]       imm;
        logic [4:0]        sh;
        logic [31:0]       ra;
        bit                rnd;
        bit                use_ref;
        logic [31:0]       res;
        logic [4:0]        dst;
        logic [31:0]       adr;
        ex_pkg::mem_dir_e  dir;
        ex_pkg::mem_size_e sz;
        logic              sgn;
        logic              ovf;
    } row_t;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    ex_pkg::op_e       op;
    logic [31:0]       rs_val;
    logic [31:0]       rt_val;
    logic [15:0]       imm;
    logic [4:0]        shamt;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [31:0]       return_addr;
    logic              out_valid;
    logic [31:0]       result;
    logic [4:0]        dest_reg;
    logic [31:0]       mem_addr;
    ex_pkg::mem_dir_e  mem_dir;
    ex_pkg::mem_size_e mem_size;
    logic              mem_signed;
    logic              overflow;
    logic              busy;

    row_t        rows[$];
    logic [31:0] ref_hi;
    logic [31:0] ref_lo;
    integer      seed;
    int          errors;
    int          checks;
    bit          table_ready;

    ex_stage u_ex_stage (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input ex_pkg::op_e o, input logic [31:0] a, input logic [31:0] b,
                           input logic [15:0] im, input logic [4:0] sh, input bit rnd,
                           input bit use_ref, input logic [31:0] res, input logic [4:0] dst,
                           input logic [31:0] adr,
                           input ex_pkg::mem_dir_e dir, input ex_pkg::mem_size_e sz,
                           input logic sgn, input logic ovf);
        row_t r;
        r.op = o;
        r.rs = a;
        r.rt = b;
        r.imm = im;
        r.sh = sh;
        r.ra = 32'h0040_0008;
        r.rnd = rnd;
        r.use_ref = use_ref;
        r.res = res;
        r.dst = dst;
        r.adr = adr;
        r.dir = dir;
        r.sz = sz;
        r.sgn = sgn;
        r.ovf = ovf;
        rows.push_back(r);
    endtask

    // single-cycle row without memory access
    task automatic alu_row(input ex_pkg::op_e o, input logic [31:0] a, input logic [31:0] b,
                           input logic [15:0] im, input logic [4:0] sh,
                           input logic [31:0] res, input logic [4:0] dst, input logic ovf);
        add_row(o, a, b, im, sh, 0, 0, res, dst, 32'h0, ex_pkg::MEM_NONE,
                ex_pkg::MEM_WORD, 1, ovf);
    endtask

    task automatic ref_row(input ex_pkg::op_e o, input logic [31:0] a, input logic [31:0] b,
                           input bit rnd);
        add_row(o, a, b, 16'h0, 5'h0, rnd, 1, 32'h0, 5'h0, 32'h0, ex_pkg::MEM_NONE,
                ex_pkg::MEM_WORD, 1, 0);
    endtask

    task automatic md_row(input ex_pkg::op_e o, input logic [31:0] a, input logic [31:0] b,
                          input bit rnd);
        ref_row(o, a, b, rnd);
        ref_row(ex_pkg::OP_MFHI, 32'h0, 32'h0, 0);
        ref_row(ex_pkg::OP_MFLO, 32'h0, 32'h0, 0);
    endtask

    // divide reference on magnitudes with signs applied afterwards
    task automatic ref_div(input logic [31:0] a, input logic [31:0] b, input bit sgn);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] rm;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        if (mb == 0)
        begin
            q = 32'hffff_ffff;
            rm = ma;
        end
        else
        begin
            q = ma / mb;
            rm = ma % mb;
        end
        if (sgn && (a[31] ^ b[31]))
            q = -q;
        if (sgn && a[31])
            rm = -rm;
        ref_hi = rm;
        ref_lo = q;
    endtask

    task automatic ref_calc(inout row_t r);
        logic [63:0] p;
        r.res = 32'h0;
        r.dst = RD_A;
        case (r.op)
            ex_pkg::OP_ADDU: r.res = r.rs + r.rt;
            ex_pkg::OP_SUBU: r.res = r.rs - r.rt;
            ex_pkg::OP_XOR:  r.res = r.rs ^ r.rt;
            ex_pkg::OP_SLT:  r.res = {31'h0, $signed(r.rs) < $signed(r.rt)};
            ex_pkg::OP_SLTU: r.res = {31'h0, r.rs < r.rt};
            ex_pkg::OP_SRAV: r.res = $signed(r.rt) >>> r.rs[4:0];
            ex_pkg::OP_MFHI: r.res = ref_hi;
            ex_pkg::OP_MFLO: r.res = ref_lo;
            default:
            begin
                r.dst = 5'h0;
                if (r.op == ex_pkg::OP_MTHI)
                    ref_hi = r.rs;
                else if (r.op == ex_pkg::OP_MTLO)
                    ref_lo = r.rs;
                else if (r.op == ex_pkg::OP_DIV || r.op == ex_pkg::OP_DIVU)
                    ref_div(r.rs, r.rt, r.op == ex_pkg::OP_DIV);
                else
                begin
                    if (r.op == ex_pkg::OP_MULT)
                        p = {{32{r.rs[31]}}, r.rs} * {{32{r.rt[31]}}, r.rt};
                    else
                        p = {32'h0, r.rs} * {32'h0, r.rt};
                    ref_hi = p[63:32];
                    ref_lo = p[31:0];
                end
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic apply_row(input row_t r);
        int cycles;
        if (r.rnd)
        begin
            r.rs = $random(seed);
            r.rt = $random(seed);
        end
        if (r.use_ref)
            ref_calc(r);
        in_valid = 1'b1;
        op = r.op;
        rs_val = r.rs;
        rt_val = r.rt;
        imm = r.imm;
        shamt = r.sh;
        return_addr = r.ra;
        @(negedge clk);
        in_valid = 1'b0;
        check_value("out_valid", out_valid, 1);
        check_value("result", result, r.res);
        check_value("dest_reg", dest_reg, r.dst);
        check_value("overflow", overflow, r.ovf);
        check_value("mem_dir", mem_dir, r.dir);
        if (r.dir != ex_pkg::MEM_NONE)
        begin
            check_value("mem_addr", mem_addr, r.adr);
            check_value("mem_size", mem_size, r.sz);
            check_value("mem_signed", mem_signed, r.sgn);
        end
        if (r.op inside {ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_DIV, ex_pkg::OP_DIVU})
        begin
            cycles = 0;
            while (busy && cycles < 100)
            begin
                cycles++;
                @(negedge clk);
            end
            check_value("busy cycles", cycles, `EX_MD_ITER + 1);
        end
    endtask

    task automatic build_table;
        ref_row(ex_pkg::OP_MFHI, 32'h0, 32'h0, 0);
        alu_row(ex_pkg::OP_AND, 32'hf0f0_ff00, 32'h0ff0_0ff0, 16'h0, 5'd0, 32'h00f0_0f00, RD_A, 0);
        alu_row(ex_pkg::OP_ANDI, 32'hffff_ffff, 32'h0, 16'h8001, 5'd0, 32'h0000_8001, RT_A, 0);
        alu_row(ex_pkg::OP_ORI, 32'h1234_0000, 32'h0, 16'hffff, 5'd0, 32'h1234_ffff, RT_A, 0);
        alu_row(ex_pkg::OP_XORI, 32'hffff_0000, 32'h0, 16'h00ff, 5'd0, 32'hffff_00ff, RT_A, 0);
        alu_row(ex_pkg::OP_NOR, 32'h0, 32'h0, 16'h0, 5'd0, 32'hffff_ffff, RD_A, 0);
        alu_row(ex_pkg::OP_LUI, 32'h0, 32'h0, 16'habcd, 5'd0, 32'habcd_0000, RT_A, 0);
        alu_row(ex_pkg::OP_SLL, 32'h0, 32'h1, 16'h0, 5'd31, 32'h8000_0000, RD_A, 0);
        alu_row(ex_pkg::OP_SRL, 32'h0, 32'h8000_0000, 16'h0, 5'd4, 32'h0800_0000, RD_A, 0);
        alu_row(ex_pkg::OP_SRA, 32'h0, 32'h8000_0000, 16'h0, 5'd4, 32'hf800_0000, RD_A, 0);
        alu_row(ex_pkg::OP_SRAV, 32'h24, 32'hf000_0000, 16'h0, 5'd0, 32'hff00_0000, RD_A, 0);
        alu_row(ex_pkg::OP_SLLV, 32'h3, 32'h1, 16'h0, 5'd0, 32'h8, RD_A, 0);
        alu_row(ex_pkg::OP_ADD, 32'h7fff_ffff, 32'h1, 16'h0, 5'd0, 32'h8000_0000, 5'd0, 1);
        alu_row(ex_pkg::OP_ADDI, 32'h8000_0000, 32'h0, 16'hffff, 5'd0, 32'h7fff_ffff, 5'd0, 1);
        alu_row(ex_pkg::OP_SUB, 32'h8000_0000, 32'h1, 16'h0, 5'd0, 32'h7fff_ffff, 5'd0, 1);
        alu_row(ex_pkg::OP_ADDU, 32'h7fff_ffff, 32'h1, 16'h0, 5'd0, 32'h8000_0000, RD_A, 0);
        alu_row(ex_pkg::OP_ADDIU, 32'h10, 32'h0, 16'hfff0, 5'd0, 32'h0, RT_A, 0);
        alu_row(ex_pkg::OP_SLT, 32'hffff_ffff, 32'h1, 16'h0, 5'd0, 32'h1, RD_A, 0);
        alu_row(ex_pkg::OP_SLTU, 32'hffff_ffff, 32'h1, 16'h0, 5'd0, 32'h0, RD_A, 0);
        alu_row(ex_pkg::OP_SLTI, 32'hffff_ffff, 32'h0, 16'h0001, 5'd0, 32'h1, RT_A, 0);
        alu_row(ex_pkg::OP_SLTIU, 32'h1, 32'h0, 16'hffff, 5'd0, 32'h1, RT_A, 0);
        // loads return the address as result
        // stores return the store data
        add_row(ex_pkg::OP_LB, 32'h1000, 32'h0, 16'hfffc, 5'd0, 0, 0, 32'h0ffc, RT_A, 32'h0ffc,
                ex_pkg::MEM_LOAD, ex_pkg::MEM_BYTE, 1, 0);
        add_row(ex_pkg::OP_LBU, 32'h2000, 32'h0, 16'h0004, 5'd0, 0, 0, 32'h2004, RT_A, 32'h2004,
                ex_pkg::MEM_LOAD, ex_pkg::MEM_BYTE, 0, 0);
        add_row(ex_pkg::OP_LH, 32'h3000, 32'h0, 16'h0002, 5'd0, 0, 0, 32'h3002, RT_A, 32'h3002,
                ex_pkg::MEM_LOAD, ex_pkg::MEM_HALF, 1, 0);
        add_row(ex_pkg::OP_LHU, 32'h3000, 32'h0, 16'hfffe, 5'd0, 0, 0, 32'h2ffe, RT_A, 32'h2ffe,
                ex_pkg::MEM_LOAD, ex_pkg::MEM_HALF, 0, 0);
        add_row(ex_pkg::OP_LW, 32'h4000, 32'h0, 16'h0010, 5'd0, 0, 0, 32'h4010, RT_A, 32'h4010,
                ex_pkg::MEM_LOAD, ex_pkg::MEM_WORD, 1, 0);
        add_row(ex_pkg::OP_SB, 32'h100, 32'hdead_beef, 16'h0008, 5'd0, 0, 0, 32'hdead_beef,
                5'd0, 32'h0108, ex_pkg::MEM_STORE, ex_pkg::MEM_BYTE, 1, 0);
        add_row(ex_pkg::OP_SH, 32'h100, 32'h1234_5678, 16'hfff8, 5'd0, 0, 0, 32'h1234_5678,
                5'd0, 32'h00f8, ex_pkg::MEM_STORE, ex_pkg::MEM_HALF, 1, 0);
        add_row(ex_pkg::OP_SW, 32'h200, 32'h0bad_cafe, 16'h0004, 5'd0, 0, 0, 32'h0bad_cafe,
                5'd0, 32'h0204, ex_pkg::MEM_STORE, ex_pkg::MEM_WORD, 1, 0);
        alu_row(ex_pkg::OP_JAL, 32'h0, 32'h0, 16'h0, 5'd0, 32'h0040_0008, 5'd31, 0);
        alu_row(ex_pkg::OP_JALR, 32'h0, 32'h0, 16'h0, 5'd0, 32'h0040_0008, RD_A, 0);
        ref_row(ex_pkg::OP_ADDU, 32'h0, 32'h0, 1);
        ref_row(ex_pkg::OP_SUBU, 32'h0, 32'h0, 1);
        ref_row(ex_pkg::OP_XOR, 32'h0, 32'h0, 1);
        ref_row(ex_pkg::OP_SRAV, 32'h0, 32'h0, 1);
        ref_row(ex_pkg::OP_SLT, 32'h0, 32'h0, 1);
        ref_row(ex_pkg::OP_SLTU, 32'h0, 32'h0, 1);
        md_row(ex_pkg::OP_MULT, 32'hffff_fffd, 32'h7, 0);
        md_row(ex_pkg::OP_MULT, 32'h0, 32'h0, 1);
        md_row(ex_pkg::OP_MULTU, 32'h0, 32'h0, 1);
        md_row(ex_pkg::OP_DIV, 32'hffff_ff9c, 32'h7, 0);
        md_row(ex_pkg::OP_DIV, 32'h0, 32'h0, 1);
        md_row(ex_pkg::OP_DIVU, 32'h0, 32'h0, 1);
        md_row(ex_pkg::OP_DIV, 32'hffff_fff7, 32'h0, 0);
        ref_row(ex_pkg::OP_MTHI, 32'hcafe_0001, 32'h0, 0);
        ref_row(ex_pkg::OP_MTLO, 32'h0bad_f00d, 32'h0, 0);
        ref_row(ex_pkg::OP_MFHI, 32'h0, 32'h0, 0);
        ref_row(ex_pkg::OP_MFLO, 32'h0, 32'h0, 0);
    endtask

    // watchdog allows 40 cycles per row plus reset
    initial
    begin
        wait (table_ready);
        #((rows.size() * 40 + 16) * 8);
        $display("timeout: the run did not complete in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        seed = 32'hea4f36fa;
        errors = 0;
        checks = 0;
        ref_hi = 32'h0;
        ref_lo = 32'h0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        op = ex_pkg::OP_NOP;
        rs_val = 32'h0;
        rt_val = 32'h0;
        imm = 16'h0;
        shamt = 5'h0;
        rt = RT_A;
        rd = RD_A;
        return_addr = 32'h0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("busy", busy, 0);
        check_value("overflow", overflow, 0);
        check_value("mem_dir", mem_dir, ex_pkg::MEM_NONE);
        foreach (rows[i])
            apply_row(rows[i]);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_md_ctrl.sv
ex_iter_counter.sv
ex_md_datapath.sv
ex_stage.sv
ex_stage_checker.sv
tb_ex_stage.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_ex_stage -Mdir obj_dir

run: compile
	./obj_dir/Vtb_ex_stage | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
